// File: hw/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// address and data widths
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32
`define CACHE_STRB_W 4

// line geometry, 16-byte lines of four words
`define CACHE_WORDS_PER_LINE 4
`define CACHE_WSEL_W ($clog2(`CACHE_WORDS_PER_LINE))
`define CACHE_OFFSET_W 4

// 16 sets
`define CACHE_INDEX_W 4

// whatever is left of the address above index and offset
`define CACHE_TAG_W 24

// two-way set associative
`define CACHE_WAYS 2

`endif

// File: hw/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

	typedef enum logic {
		OP_LOAD  = 1'b0,
		OP_STORE = 1'b1
	} req_op_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_STORE,
		ST_MISS,
		ST_FILL
	} front_state_e;

	typedef enum logic [1:0] {
		MISS_IDLE,
		MISS_WRITEBACK,
		MISS_REFILL
	} miss_state_e;

	typedef logic [`CACHE_WORD_W-1:0] word_t;

	// word 0 sits in the low bits
	typedef word_t [`CACHE_WORDS_PER_LINE-1:0] line_t;

	typedef struct packed {
		req_op_e                   op;
		logic [`CACHE_TAG_W-1:0]   tag;
		logic [`CACHE_INDEX_W-1:0] index;
		logic [`CACHE_WSEL_W-1:0]  word;
		logic [`CACHE_STRB_W-1:0]  wstrb;
		word_t                     wdata;
	} cpu_req_t;

	typedef struct packed {
		logic                    valid;
		logic [`CACHE_TAG_W-1:0] tag;
	} tag_entry_t;

	// victim_dirty means valid and dirty
	typedef struct packed {
		logic                      victim_way;
		logic [`CACHE_TAG_W-1:0]   victim_tag;
		logic                      victim_dirty;
		line_t                     victim_line;
		logic [`CACHE_INDEX_W-1:0] index;
		logic [`CACHE_TAG_W-1:0]   req_tag;
	} miss_cmd_t;

	typedef struct packed {
		logic [`CACHE_ADDR_W-1:0] addr;
	} mem_rd_t;

	typedef struct packed {
		logic [`CACHE_ADDR_W-1:0] addr;
		line_t                    line;
	} mem_wr_t;

endpackage

// File: hw/cache_front.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_front import cache_pkg::*; (
	input  logic                            clk,
	input  logic                            rst,

	input  logic                            req_valid,
	input  cpu_req_t                        req,
	output logic                            addr_ok,
	output logic                            data_ok,
	output word_t                           rdata,

	output logic [`CACHE_INDEX_W-1:0]       rd_index,
	output logic                            rd_en,
	input  tag_entry_t [`CACHE_WAYS-1:0]    way_tag,
	input  logic [`CACHE_WAYS-1:0]          way_dirty,
	input  line_t [`CACHE_WAYS-1:0]         way_line,
	input  logic                            victim_way,

	output logic                            st_en,
	output logic                            st_way,
	output logic [`CACHE_INDEX_W-1:0]       st_index,
	output logic [`CACHE_WSEL_W-1:0]        st_word,
	output logic [`CACHE_STRB_W-1:0]        st_strb,
	output word_t                           st_data,

	output logic                            fill_en,
	output logic                            fill_way,
	output logic [`CACHE_INDEX_W-1:0]       fill_index,
	output logic [`CACHE_TAG_W-1:0]         fill_tag,
	output line_t                           fill_line,
	output logic                            fill_dirty,

	output logic                            miss_start,
	output miss_cmd_t                       miss_cmd,
	input  logic                            line_done,
	input  line_t                           line_in
);

	front_state_e state;
	front_state_e state_nxt;
	cpu_req_t req_q;
	logic way_q;
	logic [`CACHE_WAYS-1:0] hit_vec;
	logic hit;
	logic hit_way;
	logic accept;
	line_t merged_line;

	// one request at a time, so only idle takes a new one
	assign addr_ok = (state == ST_IDLE);
	assign accept = req_valid && addr_ok;

	// arrays see the index in the accept cycle and answer in ST_LOOKUP
	assign rd_en = accept;
	assign rd_index = req.index;

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			hit_vec[w] = way_tag[w].valid && (way_tag[w].tag == req_q.tag);
		end
	end

	assign hit = |hit_vec;
	assign hit_way = hit_vec[1];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (accept) begin
					state_nxt = ST_LOOKUP;
				end
			end
			ST_LOOKUP: begin
				if (!hit) begin
					state_nxt = ST_MISS;
				end else if (req_q.op == OP_STORE) begin
					state_nxt = ST_STORE;
				end else begin
					state_nxt = ST_IDLE;
				end
			end
			ST_STORE: state_nxt = ST_IDLE;
			ST_MISS: begin
				if (line_done) begin
					state_nxt = ST_FILL;
				end
			end
			ST_FILL: state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	// hit way for a store hit, victim way for a refill
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
		end
		if (state == ST_LOOKUP) begin
			way_q <= hit ? hit_way : victim_way;
		end
	end

	assign miss_start = (state == ST_LOOKUP) && !hit;

	always_comb begin
		miss_cmd.victim_way = victim_way;
		miss_cmd.victim_tag = way_tag[victim_way].tag;
		miss_cmd.victim_dirty = way_tag[victim_way].valid && way_dirty[victim_way];
		miss_cmd.victim_line = way_line[victim_way];
		miss_cmd.index = req_q.index;
		miss_cmd.req_tag = req_q.tag;
	end

	assign st_en = (state == ST_STORE);
	assign st_way = way_q;
	assign st_index = req_q.index;
	assign st_word = req_q.word;
	assign st_strb = req_q.wstrb;
	assign st_data = req_q.wdata;

	// store miss: strobed bytes land on top of the refilled word
	always_comb begin
		merged_line = line_in;
		if (req_q.op == OP_STORE) begin
			for (int b = 0; b < `CACHE_STRB_W; b++) begin
				if (req_q.wstrb[b]) begin
					merged_line[req_q.word][b*8 +: 8] = req_q.wdata[b*8 +: 8];
				end
			end
		end
	end

	assign fill_en = (state == ST_FILL);
	assign fill_way = way_q;
	assign fill_index = req_q.index;
	assign fill_tag = req_q.tag;
	assign fill_line = merged_line;
	assign fill_dirty = (req_q.op == OP_STORE);

	assign data_ok = ((state == ST_LOOKUP) && hit) || (state == ST_FILL);
	assign rdata = (state == ST_FILL) ? merged_line[req_q.word] : way_line[hit_way][req_q.word];

	// a hit answer needs exactly one matching way in the set
	a_data_ok_state: assert property (@(posedge clk) disable iff (rst)
		data_ok |-> ((state == ST_LOOKUP) && $onehot(hit_vec)) || (state == ST_FILL));

endmodule

// File: hw/cache_arrays.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_arrays import cache_pkg::*; (
	input  logic                            clk,
	input  logic                            rst,

	input  logic                            rd_en,
	input  logic [`CACHE_INDEX_W-1:0]       rd_index,
	output tag_entry_t [`CACHE_WAYS-1:0]    way_tag,
	output logic [`CACHE_WAYS-1:0]          way_dirty,
	output line_t [`CACHE_WAYS-1:0]         way_line,
	output logic                            victim_way,

	input  logic                            st_en,
	input  logic                            st_way,
	input  logic [`CACHE_INDEX_W-1:0]       st_index,
	input  logic [`CACHE_WSEL_W-1:0]        st_word,
	input  logic [`CACHE_STRB_W-1:0]        st_strb,
	input  word_t                           st_data,

	input  logic                            fill_en,
	input  logic                            fill_way,
	input  logic [`CACHE_INDEX_W-1:0]       fill_index,
	input  logic [`CACHE_TAG_W-1:0]         fill_tag,
	input  line_t                           fill_line,
	input  logic                            fill_dirty
);

	localparam int SETS = 1 << `CACHE_INDEX_W;

	line_t data_mem [`CACHE_WAYS][SETS];
	logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_WAYS][SETS];
	logic [`CACHE_WAYS-1:0][SETS-1:0] valid_r;
	logic [`CACHE_WAYS-1:0][SETS-1:0] dirty_r;
	logic [SETS-1:0] victim_r;
	logic victim_q;

	// registered read of every way at once
	always_ff @(posedge clk) begin
		if (rd_en) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				way_line[w] <= data_mem[w][rd_index];
				way_tag[w].tag <= tag_mem[w][rd_index];
				way_tag[w].valid <= valid_r[w][rd_index];
				way_dirty[w] <= dirty_r[w][rd_index];
			end
			victim_q <= victim_r[rd_index];
		end
	end

	// an empty way wins over the victim bit
	always_comb begin
		if (!way_tag[0].valid) begin
			victim_way = 1'b0;
		end else if (!way_tag[1].valid) begin
			victim_way = 1'b1;
		end else begin
			victim_way = victim_q;
		end
	end

	always_ff @(posedge clk) begin
		if (st_en) begin
			for (int b = 0; b < `CACHE_STRB_W; b++) begin
				if (st_strb[b]) begin
					data_mem[st_way][st_index][st_word][b*8 +: 8] <= st_data[b*8 +: 8];
				end
			end
		end
		if (fill_en) begin
			data_mem[fill_way][fill_index] <= fill_line;
			tag_mem[fill_way][fill_index] <= fill_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_r <= '0;
			dirty_r <= '0;
			victim_r <= '0;
		end else begin
			if (st_en) begin
				dirty_r[st_way][st_index] <= 1'b1;
			end
			if (fill_en) begin
				valid_r[fill_way][fill_index] <= 1'b1;
				dirty_r[fill_way][fill_index] <= fill_dirty;
				// next fill of this set goes to the other way
				victim_r[fill_index] <= ~victim_r[fill_index];
			end
		end
	end

	a_one_write_port: assert property (@(posedge clk) disable iff (rst)
		!(st_en && fill_en));

endmodule

// File: hw/cache_miss.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_miss import cache_pkg::*; (
	input  logic      clk,
	input  logic      rst,

	input  logic      miss_start,
	input  miss_cmd_t miss_cmd,
	output logic      line_done,
	output line_t     line_out,

	output logic      rd_valid,
	output mem_rd_t   rd,
	input  logic      ret_valid,
	input  logic      ret_last,
	input  word_t     ret_data,

	output logic      wr_valid,
	output mem_wr_t   wr,
	input  logic      wr_ready
);

	localparam int BEAT_W = `CACHE_WSEL_W + 1;

	miss_state_e state;
	miss_cmd_t cmd_q;
	logic [BEAT_W-1:0] beat_cnt;
	line_t line_q;
	logic done_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MISS_IDLE;
			beat_cnt <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				MISS_IDLE: begin
					beat_cnt <= '0;
					// clean or empty victims skip straight to the refill
					if (miss_start) begin
						state <= miss_cmd.victim_dirty ? MISS_WRITEBACK : MISS_REFILL;
					end
				end
				MISS_WRITEBACK: begin
					if (wr_ready) begin
						state <= MISS_REFILL;
					end
				end
				MISS_REFILL: begin
					if (ret_valid) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (ret_last) begin
							state <= MISS_IDLE;
							done_q <= 1'b1;
						end
					end
				end
				default: state <= MISS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (miss_start && (state == MISS_IDLE)) begin
			cmd_q <= miss_cmd;
		end
		// beats come in word order
		if ((state == MISS_REFILL) && ret_valid) begin
			line_q[beat_cnt[`CACHE_WSEL_W-1:0]] <= ret_data;
		end
	end

	// whole victim line, held until memory takes it
	assign wr_valid = (state == MISS_WRITEBACK);
	assign wr.addr = {cmd_q.victim_tag, cmd_q.index, {`CACHE_OFFSET_W{1'b0}}};
	assign wr.line = cmd_q.victim_line;

	// read request stays up until the first beat shows
	assign rd_valid = (state == MISS_REFILL) && (beat_cnt == '0);
	assign rd.addr = {cmd_q.req_tag, cmd_q.index, {`CACHE_OFFSET_W{1'b0}}};

	assign line_done = done_q;
	assign line_out = line_q;

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
		!(rd_valid && wr_valid));

	// memory must mark the fourth beat as last, so no fifth one arrives
	a_beat_limit: assert property (@(posedge clk) disable iff (rst)
		((state == MISS_REFILL) && ret_valid) |-> (beat_cnt < `CACHE_WORDS_PER_LINE));

endmodule

// File: hw/cache_top.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_top import cache_pkg::*; (
	input  logic     clk,
	input  logic     rst,

	input  logic     req_valid,
	input  cpu_req_t req,
	output logic     addr_ok,
	output logic     data_ok,
	output word_t    rdata,

	output logic     rd_valid,
	output mem_rd_t  rd,
	input  logic     ret_valid,
	input  logic     ret_last,
	input  word_t    ret_data,

	output logic     wr_valid,
	output mem_wr_t  wr,
	input  logic     wr_ready
);

	// array read port
	logic rd_en;
	logic [`CACHE_INDEX_W-1:0] rd_index;
	tag_entry_t [`CACHE_WAYS-1:0] way_tag;
	logic [`CACHE_WAYS-1:0] way_dirty;
	line_t [`CACHE_WAYS-1:0] way_line;
	logic victim_way;

	// store hit write port
	logic st_en;
	logic st_way;
	logic [`CACHE_INDEX_W-1:0] st_index;
	logic [`CACHE_WSEL_W-1:0] st_word;
	logic [`CACHE_STRB_W-1:0] st_strb;
	word_t st_data;

	// refill write port
	logic fill_en;
	logic fill_way;
	logic [`CACHE_INDEX_W-1:0] fill_index;
	logic [`CACHE_TAG_W-1:0] fill_tag;
	line_t fill_line;
	logic fill_dirty;

	logic miss_start;
	miss_cmd_t miss_cmd;
	logic line_done;
	line_t line_in;

	cache_front i_front (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.addr_ok    (addr_ok),
		.data_ok    (data_ok),
		.rdata      (rdata),
		.rd_index   (rd_index),
		.rd_en      (rd_en),
		.way_tag    (way_tag),
		.way_dirty  (way_dirty),
		.way_line   (way_line),
		.victim_way (victim_way),
		.st_en      (st_en),
		.st_way     (st_way),
		.st_index   (st_index),
		.st_word    (st_word),
		.st_strb    (st_strb),
		.st_data    (st_data),
		.fill_en    (fill_en),
		.fill_way   (fill_way),
		.fill_index (fill_index),
		.fill_tag   (fill_tag),
		.fill_line  (fill_line),
		.fill_dirty (fill_dirty),
		.miss_start (miss_start),
		.miss_cmd   (miss_cmd),
		.line_done  (line_done),
		.line_in    (line_in)
	);

	cache_arrays i_arrays (
		.clk        (clk),
		.rst        (rst),
		.rd_en      (rd_en),
		.rd_index   (rd_index),
		.way_tag    (way_tag),
		.way_dirty  (way_dirty),
		.way_line   (way_line),
		.victim_way (victim_way),
		.st_en      (st_en),
		.st_way     (st_way),
		.st_index   (st_index),
		.st_word    (st_word),
		.st_strb    (st_strb),
		.st_data    (st_data),
		.fill_en    (fill_en),
		.fill_way   (fill_way),
		.fill_index (fill_index),
		.fill_tag   (fill_tag),
		.fill_line  (fill_line),
		.fill_dirty (fill_dirty)
	);

	cache_miss i_miss (
		.clk        (clk),
		.rst        (rst),
		.miss_start (miss_start),
		.miss_cmd   (miss_cmd),
		.line_done  (line_done),
		.line_out   (line_in),
		.rd_valid   (rd_valid),
		.rd         (rd),
		.ret_valid  (ret_valid),
		.ret_last   (ret_last),
		.ret_data   (ret_data),
		.wr_valid   (wr_valid),
		.wr         (wr),
		.wr_ready   (wr_ready)
	);

endmodule

// File: tb/cache_mem_model.sv
`timescale 1ns/10ps

module cache_mem_model import cache_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  int      max_delay,

	input  logic    rd_valid,
	input  mem_rd_t rd,
	output logic    ret_valid,
	output logic    ret_last,
	output word_t   ret_data,

	input  logic    wr_valid,
	input  mem_wr_t wr,
	output logic    wr_ready
);

	// only words that were written back are stored
	word_t mem [logic [31:0]];

	// traffic seen by memory, read by the testbench
	mem_wr_t wb_log [$];
	logic [31:0] rd_log [$];
	bit ev_is_wr [$];

	function automatic word_t read_word(logic [31:0] addr);
		if (mem.exists(addr)) begin
			return mem[addr];
		end
		return addr ^ 32'hA5A5_0000;
	endfunction

	task automatic random_wait();
		int n;
		n = $urandom % (max_delay + 1);
		repeat (n) @(negedge clk);
	endtask

	initial begin
		logic [31:0] base;
		ret_valid = 1'b0;
		ret_last = 1'b0;
		ret_data = '0;
		wr_ready = 1'b0;
		forever begin
			@(negedge clk);
			if (!rst && wr_valid) begin
				random_wait();
				wr_ready = 1'b1;
				wb_log.push_back(wr);
				ev_is_wr.push_back(1'b1);
				for (int i = 0; i < 4; i++) begin
					mem[wr.addr + 4 * i] = wr.line[i];
				end
				@(negedge clk);
				wr_ready = 1'b0;
			end else if (!rst && rd_valid) begin
				base = rd.addr;
				rd_log.push_back(base);
				ev_is_wr.push_back(1'b0);
				// four beats in word order, gaps allowed
				for (int i = 0; i < 4; i++) begin
					random_wait();
					ret_valid = 1'b1;
					ret_last = (i == 3);
					ret_data = read_word(base + 4 * i);
					@(negedge clk);
					ret_valid = 1'b0;
					ret_last = 1'b0;
				end
			end
		end
	end

endmodule

// File: tb/tb_cache.sv
`timescale 1ns/10ps

module tb_cache import cache_pkg::*; ();

	localparam int TESTS = 6;
	localparam int TEST_CYCLES = 200;
	localparam int CLK_NS = 20;
	localparam int RESP_LIMIT = 150;

	logic clk;
	logic rst;
	logic req_valid;
	cpu_req_t req;
	logic addr_ok;
	logic data_ok;
	word_t rdata;
	logic rd_valid;
	mem_rd_t rd;
	logic ret_valid;
	logic ret_last;
	word_t ret_data;
	logic wr_valid;
	mem_wr_t wr;
	logic wr_ready;
	int mem_delay;

	int errors;
	int failed_tests;
	int err0;
	int last_lat;
	word_t last_data;
	word_t shadow [logic [31:0]];

	cache_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.addr_ok   (addr_ok),
		.data_ok   (data_ok),
		.rdata     (rdata),
		.rd_valid  (rd_valid),
		.rd        (rd),
		.ret_valid (ret_valid),
		.ret_last  (ret_last),
		.ret_data  (ret_data),
		.wr_valid  (wr_valid),
		.wr        (wr),
		.wr_ready  (wr_ready)
	);

	cache_mem_model i_mem (
		.clk       (clk),
		.rst       (rst),
		.max_delay (mem_delay),
		.rd_valid  (rd_valid),
		.rd        (rd),
		.ret_valid (ret_valid),
		.ret_last  (ret_last),
		.ret_data  (ret_data),
		.wr_valid  (wr_valid),
		.wr        (wr),
		.wr_ready  (wr_ready)
	);

	always #10 clk = ~clk;

	initial begin
		#(TESTS * TEST_CYCLES * CLK_NS);
		$display("watchdog expired before all tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

	function automatic word_t shadow_word(logic [31:0] addr);
		if (shadow.exists(addr)) begin
			return shadow[addr];
		end
		return addr ^ 32'hA5A5_0000;
	endfunction

	function automatic logic [31:0] line_of(logic [31:0] addr);
		return {addr[31:4], 4'h0};
	endfunction

	task automatic shadow_store(logic [31:0] addr, logic [3:0] strb, word_t data);
		word_t w;
		w = shadow_word(addr);
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				w[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		shadow[addr] = w;
	endtask

	task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
		$display("ERR %0t ns %s expected %h got %h", $time, name, exp, act);
		errors++;
	endtask

	task automatic report_failure(string msg);
		$display("at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic close_test(string name);
		if (errors == err0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - err0);
			failed_tests++;
		end
		err0 = errors;
	endtask

	// one request, returns after data_ok
	task automatic access(req_op_e op, logic [31:0] addr, logic [3:0] strb, word_t wdata);
		@(negedge clk);
		while (!addr_ok) begin
			@(negedge clk);
		end
		req_valid = 1'b1;
		req.op = op;
		// tag, index, word select of a word-aligned address
		req.tag = addr[31:8];
		req.index = addr[7:4];
		req.word = addr[3:2];
		req.wstrb = strb;
		req.wdata = wdata;
		@(negedge clk);
		req_valid = 1'b0;
		last_lat = 1;
		while (!data_ok && last_lat < RESP_LIMIT) begin
			@(negedge clk);
			last_lat++;
		end
		if (!data_ok) begin
			report_failure($sformatf("no data_ok for request to %h", addr));
		end
		last_data = rdata;
	endtask

	// memory traffic caused by the last request
	task automatic check_traffic(logic [31:0] addr, int rd0, int wb0, int reads, int wbs,
			logic [31:0] victim);
		int n;
		if (i_mem.rd_log.size() != rd0 + reads) begin
			report_failure($sformatf("%0d line reads for %h, expected %0d",
				i_mem.rd_log.size() - rd0, addr, reads));
		end else if (reads == 1 && i_mem.rd_log[rd0] !== line_of(addr)) begin
			report_mismatch("rd.addr", line_of(addr), i_mem.rd_log[rd0]);
		end
		if (i_mem.wb_log.size() != wb0 + wbs) begin
			report_failure($sformatf("%0d writebacks for %h, expected %0d",
				i_mem.wb_log.size() - wb0, addr, wbs));
		end else if (wbs == 1) begin
			n = i_mem.ev_is_wr.size();
			if (i_mem.wb_log[wb0].addr !== victim) begin
				report_mismatch("wr.addr", victim, i_mem.wb_log[wb0].addr);
			end
			for (int i = 0; i < 4; i++) begin
				if (i_mem.wb_log[wb0].line[i] !== shadow_word(victim + 4 * i)) begin
					report_mismatch($sformatf("wr.line[%0d]", i), shadow_word(victim + 4 * i),
						i_mem.wb_log[wb0].line[i]);
				end
			end
			if (!(i_mem.ev_is_wr[n-2] && !i_mem.ev_is_wr[n-1])) begin
				report_failure("writeback did not come before the refill");
			end
		end
	endtask

	// reads = 0 means a hit, which must answer one cycle after accept
	task automatic request(req_op_e op, logic [31:0] addr, logic [3:0] strb, word_t wdata,
			int reads, int wbs, logic [31:0] victim);
		int rd0;
		int wb0;
		rd0 = i_mem.rd_log.size();
		wb0 = i_mem.wb_log.size();
		access(op, addr, strb, wdata);
		if (op == OP_LOAD) begin
			if (last_data !== shadow_word(addr)) begin
				report_mismatch("rdata", shadow_word(addr), last_data);
			end
		end else begin
			shadow_store(addr, strb, wdata);
		end
		if (reads == 0 && last_lat != 1) begin
			report_mismatch("data_ok latency", 32'd1, last_lat);
		end
		check_traffic(addr, rd0, wb0, reads, wbs, victim);
	endtask

	task automatic reset_then_first_miss();
		if (addr_ok !== 1'b1) begin
			report_mismatch("addr_ok", 32'd1, 32'(addr_ok));
		end
		if (data_ok !== 1'b0) begin
			report_mismatch("data_ok", 32'd0, 32'(data_ok));
		end
		if (rd_valid !== 1'b0) begin
			report_mismatch("rd_valid", 32'd0, 32'(rd_valid));
		end
		if (wr_valid !== 1'b0) begin
			report_mismatch("wr_valid", 32'd0, 32'(wr_valid));
		end
		request(OP_LOAD, 32'h0000_1234, 4'h0, '0, 1, 0, '0);
	endtask

	task automatic load_hits_same_line();
		request(OP_LOAD, 32'h0000_1230, 4'h0, '0, 0, 0, '0);
		request(OP_LOAD, 32'h0000_1238, 4'h0, '0, 0, 0, '0);
		request(OP_LOAD, 32'h0000_123C, 4'h0, '0, 0, 0, '0);
	endtask

	task automatic store_hit_partial();
		request(OP_STORE, 32'h0000_1238, 4'b0101, 32'h1122_3344, 0, 0, '0);
		request(OP_LOAD, 32'h0000_1238, 4'h0, '0, 0, 0, '0);
	endtask

	task automatic store_miss_allocate();
		request(OP_STORE, 32'h0000_5678, 4'b1100, 32'hDEAD_BEEF, 1, 0, '0);
		request(OP_LOAD, 32'h0000_5678, 4'h0, '0, 0, 0, '0);
		request(OP_LOAD, 32'h0000_5674, 4'h0, '0, 0, 0, '0);
	endtask

	// three tags in one set, starting with both ways empty
	task automatic eviction(logic [3:0] set, logic [23:0] t0, logic [23:0] t1, logic [23:0] t2);
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		a0 = {t0, set, 4'h4};
		a1 = {t1, set, 4'h8};
		a2 = {t2, set, 4'hC};
		request(OP_LOAD, a0, 4'h0, '0, 1, 0, '0);
		request(OP_STORE, a1, 4'b0011, 32'h5A5A_0F0F ^ a1, 1, 0, '0);
		// victim bit back on way 0, which is clean
		request(OP_LOAD, a2, 4'h0, '0, 1, 0, '0);
		// now way 1 with the dirty line goes
		request(OP_LOAD, a0, 4'h0, '0, 1, 1, line_of(a1));
		// stored bytes come back from memory
		request(OP_LOAD, a1, 4'h0, '0, 1, 0, '0);
		request(OP_LOAD, a0, 4'h0, '0, 0, 0, '0);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		mem_delay = 5;
		errors = 0;
		failed_tests = 0;
		err0 = 0;
		void'($urandom(12));
		repeat (2) @(negedge clk);
		rst = 1'b0;
		reset_then_first_miss();
		close_test("1 reset and first miss");
		load_hits_same_line();
		close_test("2 load hit");
		store_hit_partial();
		close_test("3 store hit");
		store_miss_allocate();
		close_test("4 store miss");
		eviction(4'h9, 24'h00_0100, 24'h00_0200, 24'h00_0300);
		close_test("5 eviction");
		mem_delay = 10;
		eviction(4'hC, 24'h00_0A00, 24'h00_0B00, 24'h00_0C00);
		close_test("6 back-pressure");
		$display("%0d tests, %0d failed, %0d errors", TESTS, failed_tests, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+hw
hw/cache_pkg.sv
hw/cache_front.sv
hw/cache_arrays.sv
hw/cache_miss.sv
hw/cache_top.sv
tb/cache_mem_model.sv
tb/tb_cache.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_cache -o tb_cache > build.log 2>&1 \
	&& ./obj_dir/tb_cache > sim.log 2>&1 \
	|| echo "build or simulation did not complete, see build.log and sim.log"
grep -q "^PASS: all tests$" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
